//--- bpu_top.f
bpu_pkg.sv
res_intake.sv
gshare.sv
btb.sv
pred_out.sv
bpu_top.sv
tb_bpu.sv

//--- Makefile
# Verilator build and run for the branch prediction unit testbench
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= bpu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/100ps

.PHONY: sim clean

# A $fatal in the run gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_bpu.sv
// Directed testbench for bpu_top with HLEN 4 and BTB_BITS 3; stops at the first mismatch
`timescale 1ns/100ps

module tb_bpu import bpu_pkg::*; ();

  localparam int HLEN         = 4;
  localparam int BTB_BITS     = 3;
  localparam int PHT_ROWS     = 1 << HLEN;
  localparam int BTB_ROWS     = 1 << BTB_BITS;
  localparam int TAG_LO       = BTB_BITS + OFFSET;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_ROUNDS  = 200;
  // Handshakes per test (reset 4, training 16, alias 1, hysteresis 4, flush 24) plus random mix
  localparam int HANDSHAKES   = 4 + 16 + 1 + 4 + 24 + 2 * RAND_ROUNDS;
  localparam int LIMIT_CYCLES = RESET_CYCLES + 50 * HANDSHAKES;

  logic            clk_i;
  logic            rst_n_i;
  logic            flush_i;
  logic            res_req_i;
  logic [XLEN-1:0] res_pc_i;
  logic            res_taken_i;
  logic [XLEN-1:0] res_target_i;
  logic            res_ack_o;
  logic            fetch_req_i;
  logic [XLEN-1:0] fetch_pc_i;
  logic            fetch_ack_o;
  logic            pred_taken_o;
  logic [XLEN-1:0] next_pc_o;

  // Reference state of history, counters and BTB
  logic [HLEN-1:0] m_hist;
  c2b_t            m_pht    [PHT_ROWS];
  logic            m_valid  [BTB_ROWS];
  logic [XLEN-1:0] m_pc     [BTB_ROWS];
  logic [XLEN-1:0] m_target [BTB_ROWS];

  bpu_top #(.HLEN(HLEN), .BTB_BITS(BTB_BITS)) UUT (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
    .res_req_i(res_req_i), .res_pc_i(res_pc_i), .res_taken_i(res_taken_i),
    .res_target_i(res_target_i), .res_ack_o(res_ack_o),
    .fetch_req_i(fetch_req_i), .fetch_pc_i(fetch_pc_i), .fetch_ack_o(fetch_ack_o),
    .pred_taken_o(pred_taken_o), .next_pc_o(next_pc_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic logic [HLEN-1:0] pht_index(input logic [XLEN-1:0] pc);
    return m_hist ^ pc[HLEN+OFFSET-1:OFFSET];
  endfunction

  // Keeps the upper bits of base but hashes to idx under the current history
  function automatic logic [XLEN-1:0] pc_for_index(input logic [XLEN-1:0] base,
                                                   input logic [HLEN-1:0] idx);
    logic [XLEN-1:0] pc;
    pc = base;
    pc[HLEN+OFFSET-1:OFFSET] = m_hist ^ idx;
    return pc;
  endfunction

  task automatic reset_model();
    m_hist = '0;
    for (int i = 0; i < PHT_ROWS; i++) begin
      m_pht[i] = SNT;
    end
    for (int i = 0; i < BTB_ROWS; i++) begin
      m_valid[i] = 1'b0;
    end
  endtask

  task automatic model_resolve(input logic [XLEN-1:0] pc, input logic taken,
                               input logic [XLEN-1:0] target);
    logic [HLEN-1:0]     idx;
    logic [BTB_BITS-1:0] bidx;
    idx  = pht_index(pc);
    bidx = pc[TAG_LO-1:OFFSET];
    // Saturating step with counter and history both on the old history
    if (taken && m_pht[idx] != ST) begin
      m_pht[idx] = c2b_t'(2'(m_pht[idx]) + 2'd1);
    end else if (!taken && m_pht[idx] != SNT) begin
      m_pht[idx] = c2b_t'(2'(m_pht[idx]) - 2'd1);
    end
    m_hist = {m_hist[HLEN-2:0], taken};
    if (taken) begin
      m_valid[bidx]  = 1'b1;
      m_pc[bidx]     = pc;
      m_target[bidx] = target;
    end
  endtask

  task automatic expect_prediction(input logic [XLEN-1:0] pc, output logic exp_taken,
                                   output logic [XLEN-1:0] exp_next);
    logic [BTB_BITS-1:0] bidx;
    logic                hit;
    bidx      = pc[TAG_LO-1:OFFSET];
    hit       = m_valid[bidx] && (m_pc[bidx][XLEN-1:TAG_LO] == pc[XLEN-1:TAG_LO]);
    exp_taken = m_pht[pht_index(pc)][1];
    exp_next  = (exp_taken && hit) ? m_target[bidx] : pc + 32'd4;
  endtask

  // ------------------------------
  // Checks and handshakes
  // ------------------------------

  task automatic check_word(input string what, input logic [XLEN-1:0] pc,
                            input logic [XLEN-1:0] exp_v, input logic [XLEN-1:0] got_v);
    assert (got_v === exp_v) else begin
      $display("[ERROR] %0t: %s at PC 0x%08h, expected 0x%08h, got 0x%08h",
               $time, what, pc, exp_v, got_v);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic send_resolution(input logic [XLEN-1:0] pc, input logic taken,
                                 input logic [XLEN-1:0] target);
    @(negedge clk_i);
    res_pc_i     = pc;
    res_taken_i  = taken;
    res_target_i = target;
    res_req_i    = 1'b1;
    while (!res_ack_o) begin
      @(negedge clk_i);
    end
    model_resolve(pc, taken, target);
    res_req_i = 1'b0;
    while (res_ack_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic do_fetch(input logic [XLEN-1:0] pc, output logic got_taken,
                          output logic [XLEN-1:0] got_next);
    logic            exp_taken;
    logic [XLEN-1:0] exp_next;
    @(negedge clk_i);
    fetch_pc_i  = pc;
    fetch_req_i = 1'b1;
    while (!fetch_ack_o) begin
      @(negedge clk_i);
    end
    expect_prediction(pc, exp_taken, exp_next);
    check_word("pred_taken_o", pc, XLEN'(exp_taken), XLEN'(pred_taken_o));
    check_word("next_pc_o", pc, exp_next, next_pc_o);
    got_taken   = pred_taken_o;
    got_next    = next_pc_o;
    fetch_req_i = 1'b0;
    while (fetch_ack_o) begin
      @(negedge clk_i);
    end
  endtask

  // Fetch that must fall through to the next word
  task automatic fetch_sequential(input logic [XLEN-1:0] pc);
    logic            t;
    logic [XLEN-1:0] n;
    do_fetch(pc, t, n);
    check_word("cold taken flag", pc, '0, XLEN'(t));
    check_word("cold next PC", pc, pc + 32'd4, n);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  localparam logic [XLEN-1:0] BR_PC  = 32'h0000_2048;
  localparam logic [XLEN-1:0] BR_TGT = 32'h0000_3000;

  task automatic check_cold_tables();
    fetch_sequential(32'h0000_1000);
    fetch_sequential(32'h0000_1044);
    fetch_sequential(32'h8000_00FC);
    fetch_sequential(32'h0FFF_FFF0);
  endtask

  task automatic train_branch();
    logic            t;
    logic [XLEN-1:0] n;
    // History fills with ones, then the same counter saturates
    for (int i = 0; i < 8; i++) begin
      send_resolution(BR_PC, 1'b1, BR_TGT);
      do_fetch(BR_PC, t, n);
    end
    check_word("trained taken flag", BR_PC, 32'd1, XLEN'(t));
    check_word("trained target", BR_PC, BR_TGT, n);
  endtask

  task automatic check_tag_mismatch();
    logic            t;
    logic [XLEN-1:0] n;
    logic [XLEN-1:0] alias_pc;
    // Bit 12 lies above both indices, so only the tag differs
    alias_pc = BR_PC ^ 32'h0000_1000;
    do_fetch(alias_pc, t, n);
    check_word("alias taken flag", alias_pc, 32'd1, XLEN'(t));
    check_word("alias next PC", alias_pc, alias_pc + 32'd4, n);
  endtask

  task automatic check_hysteresis();
    logic            t;
    logic [XLEN-1:0] n;
    logic [HLEN-1:0] sat_idx;
    logic [XLEN-1:0] probe;
    sat_idx = pht_index(BR_PC);
    // Each not-taken hits the saturated counter despite the shifting history
    for (int step = 0; step < 2; step++) begin
      probe = pc_for_index(BR_PC, sat_idx);
      send_resolution(probe, 1'b0, '0);
      probe = pc_for_index(BR_PC, sat_idx);
      do_fetch(probe, t, n);
      check_word("hysteresis taken flag", probe, (step == 0) ? 32'd1 : 32'd0, XLEN'(t));
    end
  endtask

  task automatic check_flush();
    logic            t;
    logic [XLEN-1:0] n;
    logic [HLEN-1:0] row;
    // Tables predict taken with a BTB hit at BR_PC before the flush
    train_branch();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    reset_model();
    check_cold_tables();
    fetch_sequential(BR_PC);
    // Two taken branches in other BTB rows lift the counter BR_PC will hash to
    // so a stale BTB entry would redirect it
    row = {m_hist[HLEN-3:0], 2'b11} ^ BR_PC[HLEN+OFFSET-1:OFFSET];
    send_resolution(pc_for_index(32'h0000_5000, row), 1'b1, 32'h0000_6000);
    send_resolution(pc_for_index(32'h0000_5000, row), 1'b1, 32'h0000_6000);
    do_fetch(BR_PC, t, n);
    check_word("flushed BTB taken flag", BR_PC, 32'd1, XLEN'(t));
    check_word("flushed BTB next PC", BR_PC, BR_PC + 32'd4, n);
  endtask

  task automatic random_mix();
    logic            t;
    logic [XLEN-1:0] n;
    logic [XLEN-1:0] pc;
    // Narrow PC window so entries alias and counters train
    for (int i = 0; i < RAND_ROUNDS; i++) begin
      pc = 32'h0000_4000 | ($urandom & 32'h0000_07FC);
      send_resolution(pc, 1'($urandom & 1), $urandom & 32'hFFFF_FFFC);
      do_fetch(pc, t, n);
    end
  endtask

  // ------------------------------
  // Run control
  // ------------------------------

  initial begin
    void'($urandom(11));
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    flush_i      = 1'b0;
    res_req_i    = 1'b0;
    res_pc_i     = '0;
    res_taken_i  = 1'b0;
    res_target_i = '0;
    fetch_req_i  = 1'b0;
    fetch_pc_i   = '0;
    reset_model();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    check_word("res_ack_o after reset", '0, '0, XLEN'(res_ack_o));
    check_word("fetch_ack_o after reset", '0, '0, XLEN'(fetch_ack_o));
    check_cold_tables();
    train_branch();
    // Alias check needs the counter still saturated
    check_tag_mismatch();
    check_hysteresis();
    check_flush();
    random_mix();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, a handshake never completed", LIMIT_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation timeout");
  end

endmodule

//--- bpu_top.sv
// BPU top level; a resolution reaches a fetch whose ack rises two or more cycles after its own ack
`timescale 1ns/100ps

module bpu_top import bpu_pkg::*; #(
  parameter int HLEN     = 4,
  parameter int BTB_BITS = 3
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // Resolution handshake
  input  logic            res_req_i,
  input  logic [XLEN-1:0] res_pc_i,
  input  logic            res_taken_i,
  input  logic [XLEN-1:0] res_target_i,
  output logic            res_ack_o,
  // Fetch handshake
  input  logic            fetch_req_i,
  input  logic [XLEN-1:0] fetch_pc_i,
  output logic            fetch_ack_o,
  output logic            pred_taken_o,
  output logic [XLEN-1:0] next_pc_o
);

  // Update bus from intake to both tables
  logic            upd_valid;
  logic [XLEN-1:0] upd_pc;
  logic            upd_taken;
  logic [XLEN-1:0] upd_target;

  // Lookup path
  logic [XLEN-1:0] lk_pc;
  logic            pht_taken;
  logic            btb_hit;
  logic [XLEN-1:0] btb_target;

  // ------------------------------
  // Input side
  // ------------------------------

  res_intake u_res_intake (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .res_req_i    (res_req_i),
    .res_pc_i     (res_pc_i),
    .res_taken_i  (res_taken_i),
    .res_target_i (res_target_i),
    .res_ack_o    (res_ack_o),
    .upd_valid_o  (upd_valid),
    .upd_pc_o     (upd_pc),
    .upd_taken_o  (upd_taken),
    .upd_target_o (upd_target)
  );

  // ------------------------------
  // Prediction tables
  // ------------------------------

  gshare #(.HLEN(HLEN)) u_gshare (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .lk_pc_i     (lk_pc),
    .upd_valid_i (upd_valid),
    .upd_pc_i    (upd_pc),
    .upd_taken_i (upd_taken),
    .taken_o     (pht_taken)
  );

  btb #(.BTB_BITS(BTB_BITS)) u_btb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .lk_pc_i      (lk_pc),
    .upd_valid_i  (upd_valid),
    .upd_pc_i     (upd_pc),
    .upd_taken_i  (upd_taken),
    .upd_target_i (upd_target),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // ------------------------------
  // Output side
  // ------------------------------

  pred_out u_pred_out (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_pc_i   (fetch_pc_i),
    .fetch_ack_o  (fetch_ack_o),
    .pred_taken_o (pred_taken_o),
    .next_pc_o    (next_pc_o),
    .lk_pc_o      (lk_pc),
    .pht_taken_i  (pht_taken),
    .btb_hit_i    (btb_hit),
    .btb_target_i (btb_target)
  );

endmodule

//--- pred_out.sv
// Four-phase fetch responder; one request at a time, result valid only while fetch_ack_o is high
`timescale 1ns/100ps

module pred_out import bpu_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Fetch handshake
  input  logic            fetch_req_i,
  input  logic [XLEN-1:0] fetch_pc_i,
  output logic            fetch_ack_o,
  output logic            pred_taken_o,
  output logic [XLEN-1:0] next_pc_o,
  // Table lookup
  output logic [XLEN-1:0] lk_pc_o,
  input  logic            pht_taken_i,
  input  logic            btb_hit_i,
  input  logic [XLEN-1:0] btb_target_i
);

  // Sequential fetch step of 4 bytes
  localparam logic [XLEN-1:0] PC_STEP = XLEN'(1) << OFFSET;

  // IDLE waits for req, LOOK reads the tables, ACK holds the answer,
  // DROP lowers ack one cycle after req was seen low
  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOK,
    S_ACK,
    S_DROP
  } state_t;

  state_t          state_q;
  logic            ack_q;
  logic [XLEN-1:0] lk_pc_q;
  logic            pred_taken_q;
  logic [XLEN-1:0] next_pc_q;

  logic            accept;
  logic            resolve;
  logic [XLEN-1:0] next_pc_d;

  assign accept  = (state_q == S_IDLE) & fetch_req_i;
  assign resolve = (state_q == S_LOOK);

  // Redirect only when direction and target agree
  assign next_pc_d = (pht_taken_i && btb_hit_i) ? btb_target_i : lk_pc_q + PC_STEP;

  // ------------------------------
  // Handshake FSM
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (fetch_req_i) begin
            state_q <= S_LOOK;
          end
        end
        S_LOOK: begin
          state_q <= S_ACK;
          ack_q   <= 1'b1;
        end
        S_ACK: begin
          if (!fetch_req_i) begin
            state_q <= S_DROP;
          end
        end
        default: begin
          ack_q   <= 1'b0;
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Lookup PC and registered answer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lk_pc_q <= fetch_pc_i;
    end
    if (resolve) begin
      pred_taken_q <= pht_taken_i;
      next_pc_q    <= next_pc_d;
    end
  end

  assign lk_pc_o      = lk_pc_q;
  assign fetch_ack_o  = ack_q;
  assign pred_taken_o = pred_taken_q;
  assign next_pc_o    = next_pc_q;

  // Ack only answers a request that was pending
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(fetch_ack_o) |-> $past(fetch_req_i))
    else $error("pred_out: ack rose without a pending request");

endmodule

//--- btb.sv
// Direct-mapped BTB; only taken resolutions allocate, no replacement policy beyond overwrite
`timescale 1ns/100ps

module btb import bpu_pkg::*; #(
  parameter int BTB_BITS = 3
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // Lookup side
  input  logic [XLEN-1:0] lk_pc_i,
  // Update side from the resolution intake
  input  logic            upd_valid_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic            upd_taken_i,
  input  logic [XLEN-1:0] upd_target_i,
  // Lookup result
  output logic            hit_o,
  output logic [XLEN-1:0] target_o
);

  localparam int ENTRIES = 1 << BTB_BITS;

  // Tag is every PC bit above the index
  localparam int TAG_W = XLEN - BTB_BITS - OFFSET;

  // ------------------------------
  // Storage
  // ------------------------------

  // Valid bits are the only state cleared by reset and flush
  logic [ENTRIES-1:0] valid_q;

  // Tag and target arrays
  logic [TAG_W-1:0] tag_q    [ENTRIES];
  logic [XLEN-1:0]  target_q [ENTRIES];

  // Split lookup and update PCs
  logic [BTB_BITS-1:0] lk_idx;
  logic [TAG_W-1:0]    lk_tag;
  logic [BTB_BITS-1:0] upd_idx;
  logic [TAG_W-1:0]    upd_tag;

  // Entry write strobe
  logic wr_en;

  assign lk_idx  = lk_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign lk_tag  = lk_pc_i[XLEN-1:BTB_BITS+OFFSET];
  assign upd_idx = upd_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign upd_tag = upd_pc_i[XLEN-1:BTB_BITS+OFFSET];

  // Not-taken outcomes leave the entry untouched
  assign wr_en = upd_valid_i & upd_taken_i;

  // ------------------------------
  // Valid bits
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // Invalidate everything, a coincident write is dropped
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // ------------------------------
  // Tag and target write
  // ------------------------------

  // A write during flush lands here but stays invisible
  // because its valid bit is cleared in the same cycle
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd_target_i;
    end
  end

  // ------------------------------
  // Lookup
  // ------------------------------

  // Hit needs a valid entry with matching upper PC bits
  assign hit_o = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  // Target is only meaningful together with hit_o
  assign target_o = target_q[lk_idx];

endmodule

//--- gshare.sv
// Gshare direction predictor; HLEN >= 2, history is committed non-speculatively on resolution only
`timescale 1ns/100ps

module gshare import bpu_pkg::*; #(
  parameter int HLEN = 4
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // Lookup side
  input  logic [XLEN-1:0] lk_pc_i,
  // Update side from the resolution intake
  input  logic            upd_valid_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic            upd_taken_i,
  // Predicted direction for lk_pc_i
  output logic            taken_o
);

  localparam int PHT_ROWS = 1 << HLEN;

  // Global history, newest outcome in bit 0
  logic [HLEN-1:0] history_q;

  // Pattern history table
  c2b_t pht_q [PHT_ROWS];

  // Hashed indices
  logic [HLEN-1:0] idx_rd;
  logic [HLEN-1:0] idx_wr;

  // Counter value after the update at the write index
  c2b_t cnt_next;

  // Step a counter one state toward the resolved outcome
  function automatic c2b_t c2b_step(input c2b_t cur, input logic taken);
    c2b_t nxt;
    nxt = cur;
    case (cur)
      SNT: nxt = taken ? WNT : SNT;
      WNT: nxt = taken ? WT  : SNT;
      WT:  nxt = taken ? ST  : WNT;
      ST:  nxt = taken ? ST  : WT;
      default: nxt = C2B_RESET;
    endcase
    return nxt;
  endfunction

  // ------------------------------
  // Index hashing
  // ------------------------------

  // Both sides hash with the history as it stands now
  // so a pulse updates the counter picked by the old history
  assign idx_rd = history_q ^ lk_pc_i[HLEN+OFFSET-1:OFFSET];
  assign idx_wr = history_q ^ upd_pc_i[HLEN+OFFSET-1:OFFSET];

  assign cnt_next = c2b_step(pht_q[idx_wr], upd_taken_i);

  // ------------------------------
  // Global history register
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      history_q <= '0;
    end else if (flush_i) begin
      history_q <= '0;
    end else if (upd_valid_i) begin
      // Outcome enters at the low end, oldest bit drops out
      history_q <= {history_q[HLEN-2:0], upd_taken_i};
    end
  end

  // ------------------------------
  // Counter table
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= C2B_RESET;
      end
    end else if (flush_i) begin
      // Flush wins over a coincident update
      for (int i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= C2B_RESET;
      end
    end else if (upd_valid_i) begin
      pht_q[idx_wr] <= cnt_next;
    end
  end

  // MSB of the counter gives the direction
  assign taken_o = pht_q[idx_rd][1];

  // History shift needs at least two bits
  a_hlen_min: assert property (@(posedge clk_i) HLEN >= 2)
    else $error("gshare: HLEN must be at least 2");

endmodule

//--- res_intake.sv
// Four-phase resolution receiver; source must hold fields stable from req rise until ack rise
`timescale 1ns/100ps

module res_intake import bpu_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Resolution handshake from execute
  input  logic            res_req_i,
  input  logic [XLEN-1:0] res_pc_i,
  input  logic            res_taken_i,
  input  logic [XLEN-1:0] res_target_i,
  output logic            res_ack_o,
  // One-cycle update toward gshare and BTB
  output logic            upd_valid_o,
  output logic [XLEN-1:0] upd_pc_o,
  output logic            upd_taken_o,
  output logic [XLEN-1:0] upd_target_o
);

  logic            ack_q;
  logic            upd_valid_q;
  logic [XLEN-1:0] upd_pc_q;
  logic            upd_taken_q;
  logic [XLEN-1:0] upd_target_q;

  // New transaction when req is up and our ack is still down
  logic new_req;

  assign new_req = res_req_i & ~ack_q;

  // ------------------------------
  // Handshake and update pulse
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q       <= 1'b0;
      upd_valid_q <= 1'b0;
    end else begin
      // Pulse lasts one cycle since ack blocks a second accept
      upd_valid_q <= new_req;
      if (new_req) begin
        ack_q <= 1'b1;
      end else if (!res_req_i) begin
        // Return to zero once the source has released req
        ack_q <= 1'b0;
      end
    end
  end

  // Capture resolution fields together with the ack
  always_ff @(posedge clk_i) begin
    if (new_req) begin
      upd_pc_q     <= res_pc_i;
      upd_taken_q  <= res_taken_i;
      upd_target_q <= res_target_i;
    end
  end

  assign res_ack_o    = ack_q;
  assign upd_valid_o  = upd_valid_q;
  assign upd_pc_o     = upd_pc_q;
  assign upd_taken_o  = upd_taken_q;
  assign upd_target_o = upd_target_q;

  // Each handshake commits to the tables exactly once
  a_upd_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    upd_valid_o |=> !upd_valid_o)
    else $error("res_intake: update pulse held for two cycles");

endmodule

//--- bpu_pkg.sv
// Shared constants and counter type for the BPU; word-aligned 32-bit PCs only, no compressed ISA
package bpu_pkg;

  // ------------------------------
  // Address geometry
  // ------------------------------

  // Width of a PC and of a branch target
  localparam int XLEN = 32;

  // Low PC bits dropped before any table index is formed
  // Two bits since every instruction is a 4-byte word
  localparam int OFFSET = 2;

  // ------------------------------
  // Direction counter
  // ------------------------------

  // Two-bit saturating counter, MSB is the taken prediction
  typedef enum logic [1:0] {
    SNT = 2'b00,  // strongly not taken
    WNT = 2'b01,  // weakly not taken
    WT  = 2'b10,  // weakly taken
    ST  = 2'b11   // strongly taken
  } c2b_t;

  // Value loaded on reset and on flush
  localparam c2b_t C2B_RESET = SNT;

endpackage
